// ==== bench/uart_chk.sv ====
// FIFO occupancy and flag assertions.
// Bound into every uart_fifo instance.
module uart_chk (
	input logic             clk,
	input logic             reset,
	input logic             i_push,
	input logic             i_pop,
	input uart_pkg::count_t i_count,
	input logic             i_empty,
	input logic             i_full
);
	timeunit 1ns;
	timeprecision 100ps;
	import uart_pkg::*;

	// Failures seen so far
	int fail_count = 0;

	// Occupancy stays within the array
	a_count_max: assert property (@(posedge clk) disable iff (reset)
		i_count <= count_t'(FIFO_DEPTH))
		else
		begin
			fail_count++;
			$error("FIFO count above depth");
		end

	// Pointer flags agree with the count one cycle earlier
	// so full and empty can never be set together
	a_flags_count: assert property (@(posedge clk) disable iff (reset)
		(i_empty == ($past(i_count) == '0)) &&
		(i_full == ($past(i_count) == count_t'(FIFO_DEPTH))))
		else
		begin
			fail_count++;
			$error("FIFO flags disagree with the count");
		end

	// One push or one pop per cycle, and only when requested
	a_count_step: assert property (@(posedge clk) disable iff (reset)
		(i_count == $past(i_count)) ||
		((i_count == $past(i_count) + 1'b1) && $past(i_push)) ||
		((i_count == $past(i_count) - 1'b1) && $past(i_pop)))
		else
		begin
			fail_count++;
			$error("FIFO count moved without a matching request");
		end

endmodule

bind uart_fifo uart_chk u_chk (
	.clk     (clk),
	.reset   (reset),
	.i_push  (i_push),
	.i_pop   (i_pop),
	.i_count (o_count),
	.i_empty (o_empty),
	.i_full  (o_full)
);

// ==== bench/uart_tb.sv ====
// Testbench for uart_top: bus writes and reads, serial frames both ways.
// Checks data order, flags, interrupts and flow control.
module uart_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import uart_pkg::*;

	// About twice the length of all tests together
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk;
	logic reset;
	word_t wb_adr;
	logic wb_we;
	word_t wb_wdat;
	logic wb_stb;
	logic cts_n;
	logic rxd;
	word_t wb_rdat;
	logic wb_ack;
	logic uart_int;
	logic txd;
	logic rts_n;

	// Bytes written to DR and bytes decoded from txd
	byte_t exp_q[$];
	byte_t seen_q[$];
	// Bytes sent on rxd, not yet read back
	byte_t rxm_q[$];
	logic [31:0] rng;
	int cycles;
	// Start bits seen on txd
	int tx_starts;

	uart_top i_dut (
		.clk          (clk),
		.reset        (reset),
		.i_wb_adr     (wb_adr),
		.i_wb_we      (wb_we),
		.i_wb_dat     (wb_wdat),
		.i_wb_stb     (wb_stb),
		.i_uart_cts_n (cts_n),
		.i_uart_rxd   (rxd),
		.o_wb_dat     (wb_rdat),
		.o_wb_ack     (wb_ack),
		.o_uart_int   (uart_int),
		.o_uart_txd   (txd),
		.o_uart_rts_n (rts_n)
	);

	// ========================================
	// Clock, timeout and helpers
	// ========================================
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Expected interrupt in bit 8, flag register below
	function automatic logic [8:0] flag_ref(input int txc, input int rxc, input logic cts,
		input logic rxie, input logic txie);
		logic [7:0] fr;
		logic irq;
		fr = {txc == 0, rxc == FIFO_DEPTH, txc == FIFO_DEPTH, rxc == 0, txc != 0,
			1'b1, 1'b1, cts};
		irq = (txie && txc <= TX_INT_LEVEL) || (rxie && rxc >= RX_INT_LEVEL);
		return {irq, fr};
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp)
		begin
			$display("error at %0t: %s, got %h expected %h", $time, msg, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	// Leaves the caller 1 ns after a rising edge
	task automatic idle(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic bus_write(input logic [15:0] adr, input word_t dat);
		wb_adr  = {16'd0, adr};
		wb_we   = 1'b1;
		wb_wdat = dat;
		wb_stb  = 1'b1;
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		idle(1);
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] adr, output word_t dat);
		wb_adr = {16'd0, adr};
		wb_we  = 1'b0;
		wb_stb = 1'b1;
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		dat = wb_rdat;
		idle(1);
		wb_stb = 1'b0;
	endtask

	task automatic write_byte(input byte_t b);
		exp_q.push_back(b);
		bus_write(ADDR_DR, word_t'(b));
	endtask

	task automatic read_byte();
		word_t d;
		bus_read(ADDR_DR, d);
		check(d, word_t'(rxm_q.pop_front()), "byte read from DR");
	endtask

	// Start, 8 bits LSB first, two stop periods
	task automatic send_frame(input byte_t b);
		int i;
		rxm_q.push_back(b);
		rxd = 1'b0;
		idle(CLKS_PER_BIT);
		for (i = 0; i < 8; i++)
		begin
			rxd = b[i];
			idle(CLKS_PER_BIT);
		end
		rxd = 1'b1;
		idle(2 * CLKS_PER_BIT);
	endtask

	task automatic check_state(input int txc, input int rxc, input logic cts,
		input logic rxie, input logic txie, input string msg);
		word_t d;
		logic [8:0] r;
		r = flag_ref(txc, rxc, cts, rxie, txie);
		bus_read(ADDR_FR, d);
		check(d, {24'd0, r[7:0]}, msg);
		check(uart_int, r[8], msg);
	endtask

	// Margin covers the stop periods after the last decoded byte
	task automatic wait_tx_drain();
		while (exp_q.size() != 0)
			@(posedge clk);
		idle(3 * CLKS_PER_BIT);
	endtask

	// ========================================
	// Serial monitor and comparison
	// ========================================
	initial
	begin
		byte_t b;
		int i;
		tx_starts = 0;
		forever
		begin
			@(negedge txd);
			tx_starts++;
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			check(txd, 1'b0, "start bit level");
			for (i = 0; i < 8; i++)
			begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				b[i] = txd;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			check(txd, 1'b1, "stop level");
			seen_q.push_back(b);
		end
	end

	initial
	begin
		forever
		begin
			@(posedge clk);
			if (seen_q.size() != 0)
			begin
				check(exp_q.size() != 0, 1'b1, "byte on txd with none pending");
				check(seen_q.pop_front(), exp_q.pop_front(), "byte on txd");
			end
		end
	end

	// ========================================
	// Tests
	// ========================================
	initial
	begin
		word_t d;
		int i;
		int n;
		reset   = 1'b1;
		wb_adr  = '0;
		wb_we   = 1'b0;
		wb_wdat = '0;
		wb_stb  = 1'b0;
		cts_n   = 1'b0;
		rxd     = 1'b1;
		rng     = 32'hbb65;
		idle(4);
		reset = 1'b0;
		idle(4);
		check(txd, 1'b1, "txd idle after reset");

		// Transmit in order
		for (i = 0; i < 4; i++)
		begin
			rng = xorshift(rng);
			write_byte(rng[7:0]);
		end
		wait_tx_drain();
		check_state(0, 0, 1'b1, 1'b0, 1'b0, "flags after transmit");

		// Receive in order
		for (i = 0; i < 4; i++)
		begin
			rng = xorshift(rng);
			send_frame(rng[7:0]);
		end
		for (i = 0; i < 4; i++)
			read_byte();
		check_state(0, 0, 1'b1, 1'b0, 1'b0, "rx empty after reads");

		// CTS held off, FIFO fills, 17th write dropped
		cts_n = 1'b1;
		idle(8);
		n = tx_starts;
		for (i = 0; i < FIFO_DEPTH; i++)
		begin
			rng = xorshift(rng);
			write_byte(rng[7:0]);
		end
		// Flags settle two cycles after the last push
		idle(2);
		check_state(FIFO_DEPTH, 0, 1'b0, 1'b0, 1'b0, "tx full with CTS off");
		bus_write(ADDR_DR, 32'h5a);
		check_state(FIFO_DEPTH, 0, 1'b0, 1'b0, 1'b0, "tx full after dropped write");
		check(tx_starts, n, "no start bit while CTS off");
		cts_n = 1'b0;
		wait_tx_drain();
		check_state(0, 0, 1'b1, 1'b0, 1'b0, "tx empty after release");

		// Receive interrupt at the level
		bus_write(ADDR_CR, word_t'(1) << CR_RXIE_BIT);
		bus_read(ADDR_CR, d);
		check(d, word_t'(1) << CR_RXIE_BIT, "control register read back");
		for (i = 0; i < RX_INT_LEVEL; i++)
		begin
			rng = xorshift(rng);
			send_frame(rng[7:0]);
		end
		idle(4);
		check(uart_int, 1'b1, "rx interrupt at level");
		read_byte();
		idle(4);
		check(uart_int, 1'b0, "rx interrupt after one read");
		while (rxm_q.size() != 0)
			read_byte();
		check_state(0, 0, 1'b1, 1'b1, 1'b0, "rx drained");

		// Transmit interrupt and clear
		bus_write(ADDR_CR, word_t'(1) << CR_TXIE_BIT);
		idle(4);
		check(uart_int, 1'b1, "tx interrupt when empty");
		bus_write(ADDR_IIR, 32'h0);
		idle(4);
		check(uart_int, 1'b1, "tx interrupt back after clear");
		cts_n = 1'b1;
		idle(8);
		for (i = 0; i <= TX_INT_LEVEL; i++)
		begin
			rng = xorshift(rng);
			write_byte(rng[7:0]);
		end
		idle(4);
		check_state(TX_INT_LEVEL + 1, 0, 1'b0, 1'b0, 1'b1, "tx interrupt off above level");
		cts_n = 1'b0;
		wait_tx_drain();
		bus_write(ADDR_CR, 32'h0);

		// RTS with a full receive FIFO
		for (i = 0; i < FIFO_DEPTH; i++)
		begin
			rng = xorshift(rng);
			send_frame(rng[7:0]);
		end
		while (rts_n !== 1'b1)
			@(posedge clk);
		idle(1);
		bus_read(16'h0100, d);
		check(d, READ_DEFAULT, "unknown address read");
		check_state(0, FIFO_DEPTH, 1'b1, 1'b0, 1'b0, "rx full");
		while (rxm_q.size() != 0)
			read_byte();
		idle(4);
		check(rts_n, 1'b0, "RTS low after drain");

		if (i_dut.u_tx_fifo.u_chk.fail_count + i_dut.u_rx_fifo.u_chk.fail_count != 0)
		begin
			$display("the FIFO assertions failed during the run");
			$display("CHECKS FAILED");
			$fatal(1, "assertion failure");
		end
		else
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// ==== flist.f ====
verilog/uart_pkg.sv
verilog/uart_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
bench/uart_chk.sv
bench/uart_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UART testbench with Verilator.
# Exit status is zero only when the log holds no failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module uart_tb \
	-f flist.f -o uart_sim > build.log 2>&1 &&
	./obj_dir/uart_sim > sim.log 2>&1 &&
	! grep -q "CHECKS FAILED" sim.log &&
	echo "simulation passed" && exit 0 ||
	{ echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== verilog/uart_fifo.sv ====
// Byte FIFO in flip-flops with occupancy count and registered flags.
// One copy buffers transmit bytes and another buffers received bytes.
module uart_fifo (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_push,
	input  uart_pkg::byte_t  i_data,
	input  logic             i_pop,
	output uart_pkg::byte_t  o_data,
	output uart_pkg::count_t o_count,
	output logic             o_empty,
	output logic             o_full
);
	import uart_pkg::*;

	// Entry storage
	byte_t mem [FIFO_DEPTH];
	// Pointers with one extra wrap bit
	logic [FIFO_AW:0] wr_ptr;
	logic [FIFO_AW:0] rd_ptr;
	logic push_ok;
	logic pop_ok;

	// Requests qualified by the exact occupancy
	assign push_ok = i_push && (o_count != count_t'(FIFO_DEPTH));
	assign pop_ok  = i_pop && (o_count != '0);

	// Head of queue
	assign o_data = mem[rd_ptr[FIFO_AW-1:0]];

	always_ff @(posedge clk)
	begin
		if (push_ok)
		begin
			mem[wr_ptr[FIFO_AW-1:0]] <= i_data;
		end
	end

	// Pointers and count
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			o_count <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count alone
			if (push_ok && !pop_ok)
				o_count <= o_count + 1'b1;
			else if (pop_ok && !push_ok)
				o_count <= o_count - 1'b1;
		end
	end

	// Flags trail the pointers by one cycle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			o_empty <= 1'b1;
			o_full  <= 1'b0;
		end
		else
		begin
			o_empty <= (wr_ptr == rd_ptr);
			// Same index but opposite wrap bit
			o_full  <= (wr_ptr == {~rd_ptr[FIFO_AW], rd_ptr[FIFO_AW-1:0]});
		end
	end

endmodule

// ==== verilog/uart_pkg.sv ====
// Constants, types and register map shared by the UART blocks.
// Each module imports this inside its body.
package uart_pkg;

	// ======================================
	// Serial timing
	// ======================================

	// System clocks per serial bit
	localparam int CLKS_PER_BIT = 16;
	// Width of the bit period counters
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	// Cycles the glitch filter adds before a start edge is seen
	localparam int RX_FILTER_DELAY = 4;
	// Start edge to middle of start bit
	localparam int RX_HALF_COUNT = CLKS_PER_BIT / 2 - RX_FILTER_DELAY;
	// Data sample spacing less the two restart cycles
	localparam int RX_BIT_COUNT = CLKS_PER_BIT - 2;

	// ======================================
	// FIFO sizing and interrupt levels
	// ======================================

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = 4;
	localparam int RX_INT_LEVEL = 8;
	localparam int TX_INT_LEVEL = 8;

	typedef logic [7:0] byte_t;
	typedef logic [FIFO_AW:0] count_t;
	typedef logic [31:0] word_t;

	// ======================================
	// Register map
	// ======================================

	localparam logic [15:0] ADDR_DR = 16'h0000;
	localparam logic [15:0] ADDR_CR = 16'h0030;
	localparam logic [15:0] ADDR_FR = 16'h0018;
	// Status on read and interrupt clear on write
	localparam logic [15:0] ADDR_IIR = 16'h0034;
	localparam int CR_RXIE_BIT = 4;
	localparam int CR_TXIE_BIT = 5;
	localparam word_t READ_DEFAULT = 32'h00c0ffee;

endpackage

// ==== verilog/uart_regs.sv ====
// Register block on a 32-bit strobe/acknowledge bus.
// Holds the interrupt enables and builds flags, status and read data.
module uart_regs (
	input  logic             clk,
	input  logic             reset,
	input  uart_pkg::word_t  i_wb_adr,
	input  logic             i_wb_we,
	input  uart_pkg::word_t  i_wb_dat,
	input  logic             i_wb_stb,
	input  uart_pkg::byte_t  i_rx_data,
	input  uart_pkg::count_t i_tx_count,
	input  logic             i_tx_empty,
	input  logic             i_tx_full,
	input  uart_pkg::count_t i_rx_count,
	input  logic             i_rx_empty,
	input  logic             i_rx_full,
	input  logic             i_cts,
	output uart_pkg::word_t  o_wb_dat,
	output logic             o_wb_ack,
	output logic             o_tx_push,
	output uart_pkg::byte_t  o_tx_data,
	output logic             o_rx_pop,
	output logic             o_int
);
	import uart_pkg::*;

	logic start_write;
	logic start_read;
	logic read_d1;
	logic [15:0] reg_adr;
	logic rx_ie;
	logic tx_ie;
	logic tx_int;
	logic rx_int;
	word_t cr_word;
	word_t fr_word;
	word_t iir_word;

	// ======================================
	// Bus handshake
	// ======================================

	// Only the low half of the address selects a register
	assign reg_adr = i_wb_adr[15:0];

	// A pending read acknowledge blocks a write
	assign start_write = i_wb_stb && i_wb_we && !read_d1;
	assign start_read  = i_wb_stb && !i_wb_we && !o_wb_ack;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			read_d1 <= 1'b0;
		else
			read_d1 <= start_read;
	end

	// Write acks at once and read acks one cycle later
	assign o_wb_ack = i_wb_stb && (start_write || read_d1);

	// FIFO side effects
	assign o_tx_push = start_write && (reg_adr == ADDR_DR);
	assign o_tx_data = i_wb_dat[7:0];
	assign o_rx_pop  = start_read && (reg_adr == ADDR_DR);

	// Control register
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_ie <= 1'b0;
			tx_ie <= 1'b0;
		end
		else if (start_write && reg_adr == ADDR_CR)
		begin
			rx_ie <= i_wb_dat[CR_RXIE_BIT];
			tx_ie <= i_wb_dat[CR_TXIE_BIT];
		end
	end

	// ======================================
	// Interrupts
	// ======================================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			tx_int <= 1'b0;
			rx_int <= 1'b0;
		end
		else
		begin
			// Clear lasts one cycle if the level still holds
			if (start_write && reg_adr == ADDR_IIR)
				tx_int <= 1'b0;
			else
				tx_int <= (i_tx_count <= count_t'(TX_INT_LEVEL)) && tx_ie;
			rx_int <= (i_rx_count >= count_t'(RX_INT_LEVEL));
		end
	end

	assign o_int = (tx_int && tx_ie) || (rx_int && rx_ie);

	// ======================================
	// Read data
	// ======================================
	assign cr_word = (word_t'(rx_ie) << CR_RXIE_BIT) | (word_t'(tx_ie) << CR_TXIE_BIT);

	// Bits 2 and 1 carry tx and rx status
	assign iir_word = {28'd0, 1'b0, tx_int, rx_int, 1'b0};

	// Busy is tx not empty and the two fixed ones are DCD and DSR
	assign fr_word = {24'd0, i_tx_empty, i_rx_full, i_tx_full, i_rx_empty,
		!i_tx_empty, 1'b1, 1'b1, i_cts};

	// Sampled at the strobe edge and held through the ack
	always_ff @(posedge clk)
	begin
		if (start_read)
		begin
			case (reg_adr)
				ADDR_DR:  o_wb_dat <= {24'd0, i_rx_data};
				ADDR_CR:  o_wb_dat <= cr_word;
				ADDR_FR:  o_wb_dat <= fr_word;
				ADDR_IIR: o_wb_dat <= iir_word;
				default:  o_wb_dat <= READ_DEFAULT;
			endcase
		end
	end

endmodule

// ==== verilog/uart_rx.sv ====
// Receive side: glitch filtered start detect, mid-bit sampling and RTS.
// Each completed byte is pushed into the receive FIFO.
module uart_rx (
	input  logic            clk,
	input  logic            reset,
	input  logic            i_rxd,
	input  logic            i_full,
	output logic            o_push,
	output uart_pkg::byte_t o_data,
	output logic            o_rts_n
);
	import uart_pkg::*;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_MID_WAIT,
		RX_MID,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	logic [4:0] rxd_d;
	logic rx_start;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic restart;
	logic [2:0] bit_idx;
	logic rxen;
	logic sample;

	// ======================================
	// Line filter
	// ======================================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rxd_d <= 5'h1f;
		else
			rxd_d <= {rxd_d[3:0], i_rxd};
	end

	// Two high then two low samples
	// Middle sample ignored to skip a ragged edge
	assign rx_start = (rxd_d[4:3] == 2'b11) && (rxd_d[1:0] == 2'b00);

	// Restartable bit counter
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			bit_cnt <= '0;
		else if (restart)
			bit_cnt <= '0;
		else
			bit_cnt <= bit_cnt + 1'b1;
	end

	// Middle of a data or stop bit
	assign sample = (bit_cnt == BIT_CNT_W'(RX_BIT_COUNT));

	// ======================================
	// Receive FSM
	// ======================================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= RX_IDLE;
			restart <= 1'b0;
			bit_idx <= '0;
			rxen    <= 1'b0;
		end
		else
		begin
			case (state)
				// Holds RTS high while the FIFO has no room
				RX_IDLE:
					if (i_full)
						rxen <= 1'b0;
					else
					begin
						rxen    <= 1'b1;
						restart <= 1'b1;
						state   <= RX_START;
					end
				// Full flag lags a push so check again here
				RX_START:
					if (i_full)
						state <= RX_IDLE;
					else if (rx_start)
					begin
						restart <= 1'b1;
						state   <= RX_MID_WAIT;
					end
					else
						restart <= 1'b0;
				// One cycle for the counter to clear
				RX_MID_WAIT:
					state <= RX_MID;
				RX_MID:
					if (bit_cnt == BIT_CNT_W'(RX_HALF_COUNT))
					begin
						restart <= 1'b1;
						bit_idx <= '0;
						state   <= RX_DATA;
					end
					else
						restart <= 1'b0;
				RX_DATA:
					if (sample)
					begin
						restart <= 1'b1;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
					else
						restart <= 1'b0;
				// Byte goes to the FIFO mid stop bit
				RX_STOP:
					if (sample)
					begin
						restart <= 1'b1;
						state   <= RX_IDLE;
					end
					else
						restart <= 1'b0;
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// Shift in LSB first from the filtered line
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && sample)
			o_data <= {rxd_d[0], o_data[7:1]};
	end

	assign o_push  = (state == RX_STOP) && sample;
	assign o_rts_n = ~rxen;

endmodule

// ==== verilog/uart_top.sv ====
// UART top level with transmit and receive FIFOs behind a register block.
// Bus on one side and the four serial pins on the other.
module uart_top (
	input  logic            clk,
	input  logic            reset,
	input  uart_pkg::word_t i_wb_adr,
	input  logic            i_wb_we,
	input  uart_pkg::word_t i_wb_dat,
	input  logic            i_wb_stb,
	input  logic            i_uart_cts_n,
	input  logic            i_uart_rxd,
	output uart_pkg::word_t o_wb_dat,
	output logic            o_wb_ack,
	output logic            o_uart_int,
	output logic            o_uart_txd,
	output logic            o_uart_rts_n
);
	import uart_pkg::*;

	// Transmit path
	logic tx_push;
	byte_t tx_wdata;
	logic tx_pop;
	byte_t tx_head;
	count_t tx_count;
	logic tx_empty;
	logic tx_full;
	logic cts;

	// Receive path
	logic rx_push;
	byte_t rx_wdata;
	logic rx_pop;
	byte_t rx_head;
	count_t rx_count;
	logic rx_empty;
	logic rx_full;

	// ======================================
	// Transmit
	// ======================================
	uart_fifo u_tx_fifo (
		.clk     (clk),
		.reset   (reset),
		.i_push  (tx_push),
		.i_data  (tx_wdata),
		.i_pop   (tx_pop),
		.o_data  (tx_head),
		.o_count (tx_count),
		.o_empty (tx_empty),
		.o_full  (tx_full)
	);

	uart_tx u_tx (
		.clk     (clk),
		.reset   (reset),
		.i_cts_n (i_uart_cts_n),
		.i_data  (tx_head),
		.i_empty (tx_empty),
		.o_pop   (tx_pop),
		.o_txd   (o_uart_txd),
		.o_cts   (cts)
	);

	// ======================================
	// Receive
	// ======================================
	uart_fifo u_rx_fifo (
		.clk     (clk),
		.reset   (reset),
		.i_push  (rx_push),
		.i_data  (rx_wdata),
		.i_pop   (rx_pop),
		.o_data  (rx_head),
		.o_count (rx_count),
		.o_empty (rx_empty),
		.o_full  (rx_full)
	);

	uart_rx u_rx (
		.clk     (clk),
		.reset   (reset),
		.i_rxd   (i_uart_rxd),
		.i_full  (rx_full),
		.o_push  (rx_push),
		.o_data  (rx_wdata),
		.o_rts_n (o_uart_rts_n)
	);

	// Registers and interrupt
	uart_regs u_regs (
		.clk        (clk),
		.reset      (reset),
		.i_wb_adr   (i_wb_adr),
		.i_wb_we    (i_wb_we),
		.i_wb_dat   (i_wb_dat),
		.i_wb_stb   (i_wb_stb),
		.i_rx_data  (rx_head),
		.i_tx_count (tx_count),
		.i_tx_empty (tx_empty),
		.i_tx_full  (tx_full),
		.i_rx_count (rx_count),
		.i_rx_empty (rx_empty),
		.i_rx_full  (rx_full),
		.i_cts      (cts),
		.o_wb_dat   (o_wb_dat),
		.o_wb_ack   (o_wb_ack),
		.o_tx_push  (tx_push),
		.o_tx_data  (tx_wdata),
		.o_rx_pop   (rx_pop),
		.o_int      (o_uart_int)
	);

endmodule

// ==== verilog/uart_tx.sv ====
// Transmit side: bit rate divider, CTS synchronizer and frame FSM.
// Reads bytes from the head of the transmit FIFO.
module uart_tx (
	input  logic            clk,
	input  logic            reset,
	input  logic            i_cts_n,
	input  uart_pkg::byte_t i_data,
	input  logic            i_empty,
	output logic            o_pop,
	output logic            o_txd,
	output logic            o_cts
);
	import uart_pkg::*;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP1,
		TX_STOP2,
		TX_STOP3
	} tx_state_t;

	tx_state_t state;
	logic [BIT_CNT_W-1:0] div_cnt;
	logic bit_pulse;
	logic [3:0] cts_n_d;
	logic cts_ok;
	logic [2:0] bit_idx;

	// ======================================
	// Bit period divider
	// ======================================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			div_cnt   <= '0;
			bit_pulse <= 1'b0;
		end
		else if (div_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1))
		begin
			div_cnt   <= '0;
			bit_pulse <= 1'b1;
		end
		else
		begin
			div_cnt   <= div_cnt + 1'b1;
			bit_pulse <= 1'b0;
		end
	end

	// CTS shift register, idles deasserted
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cts_n_d <= 4'hf;
		else
			cts_n_d <= {cts_n_d[2:0], i_cts_n};
	end

	// Three settled samples low
	assign cts_ok = (cts_n_d[3:1] == 3'b000);
	assign o_cts  = ~cts_n_d[3];

	// ======================================
	// Frame FSM
	// ======================================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= TX_IDLE;
			o_txd   <= 1'b1;
			bit_idx <= '0;
		end
		else
		begin
			case (state)
				// Waits for data and CTS
				TX_IDLE:
					if (cts_ok && !i_empty)
						state <= TX_START;
				// Rechecks on the bit edge since flags lag a pop
				TX_START:
					if (bit_pulse)
					begin
						if (cts_ok && !i_empty)
						begin
							o_txd   <= 1'b0;
							bit_idx <= '0;
							state   <= TX_DATA;
						end
						else
							state <= TX_IDLE;
					end
				// LSB first
				TX_DATA:
					if (bit_pulse)
					begin
						o_txd <= i_data[bit_idx];
						if (bit_idx == 3'd7)
							state <= TX_STOP1;
						else
							bit_idx <= bit_idx + 1'b1;
					end
				// Stop level starts here
				TX_STOP1:
					if (bit_pulse)
					begin
						o_txd <= 1'b1;
						state <= TX_STOP2;
					end
				TX_STOP2:
					if (bit_pulse)
						state <= TX_STOP3;
				// Single cycle pop of the sent byte
				TX_STOP3:
					state <= TX_IDLE;
				default:
				begin
					o_txd <= 1'b1;
					state <= TX_IDLE;
				end
			endcase
		end
	end

	assign o_pop = (state == TX_STOP3);

endmodule
